// ==== Bender.yml ====
package:
  name: uart_cmd

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hdl/uart_frame_pkg.sv
      - hdl/uart_ctrl_pkg.sv
      - hdl/uart_baud_timer.sv
      - hdl/uart_tx_shift.sv
      - hdl/uart_rx_shift.sv
      - hdl/uart_cmd_seq.sv
      - hdl/uart_cmd_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - sim/uart_cmd_props.sv
      - sim/tb_uart_cmd.sv

// ==== hdl/uart_baud_timer.sv ====
`include "uart_settings.svh"

module uart_baud_timer (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          run,
  input  logic                          half,
  output logic                          bit_tick,
  output uart_frame_pkg::uart_bit_idx_t bit_idx,
  output logic                          frame_done
);
  import uart_frame_pkg::*;

  localparam int DIV_W = $clog2(`UART_BAUD_DIV);

  logic [DIV_W-1:0] div_cnt;
  logic [DIV_W-1:0] div_last;
  logic             first; // No tick issued yet in this run

  // Half mode shortens only the first bit time
  assign div_last = (half && first) ? DIV_W'(`UART_HALF_DIV - 1)
                                    : DIV_W'(`UART_BAUD_DIV - 1);

  assign bit_tick   = run && (div_cnt == div_last);
  assign frame_done = bit_tick && (bit_idx == BIT_IDX_STOP);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      div_cnt <= '0;
      bit_idx <= BIT_IDX_START;
      first   <= 1'b1;
    end
    else if (!run) // Restart whenever stopped
    begin
      div_cnt <= '0;
      bit_idx <= BIT_IDX_START;
      first   <= 1'b1;
    end
    else if (bit_tick)
    begin
      div_cnt <= '0;
      first   <= 1'b0;
      bit_idx <= frame_done ? BIT_IDX_START : uart_bit_idx_t'(bit_idx + 1'b1);
    end
    else
      div_cnt <= div_cnt + 1'b1;
  end

endmodule

// ==== hdl/uart_cmd_seq.sv ====
`include "uart_settings.svh"

module uart_cmd_seq (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       cmd_req,
  input  uart_frame_pkg::uart_cmd_t  cmd,
  output logic                       cmd_ack,
  output logic                       rd_req,
  input  logic                       rd_ack,
  output uart_frame_pkg::uart_byte_t rd_data,
  output logic                       rd_err,
  output logic                       timer_run,
  output logic                       timer_half,
  input  logic                       frame_done,
  output logic                       tx_load,
  output uart_frame_pkg::uart_byte_t tx_byte,
  output logic                       rx_arm,
  input  logic                       start_seen,
  input  uart_frame_pkg::uart_byte_t rx_byte,
  input  logic                       rx_err
);
  import uart_frame_pkg::*;
  import uart_ctrl_pkg::*;

  seq_state_t state;
  seq_state_t state_nxt;
  gap_cnt_t   gap_cnt;
  logic       gap_done;
  logic       accept;
  logic       wr_q;   // Current command is a write
  uart_byte_t data_q; // Write data byte

  assign accept   = (state == SEQ_IDLE) && cmd_req && !cmd_ack;
  assign gap_done = (gap_cnt == gap_cnt_t'(`UART_GAP_CYCLES - 1));

  // --------------------------------------------------
  // State machine
  // --------------------------------------------------
  always_comb
  begin
    state_nxt = state;
    case (state)
      SEQ_IDLE:
        if (accept)
          state_nxt = SEQ_SEND_HDR;
      SEQ_SEND_HDR:
        if (frame_done)
          state_nxt = SEQ_GAP;
      SEQ_GAP:
        if (gap_done)
          state_nxt = wr_q ? SEQ_SEND_DATA : SEQ_WAIT_REPLY;
      SEQ_SEND_DATA:
        if (frame_done)
          state_nxt = SEQ_IDLE;
      SEQ_WAIT_REPLY:
        if (start_seen)
          state_nxt = SEQ_RECV;
      SEQ_RECV:
        if (frame_done)
          state_nxt = SEQ_RESPOND;
      SEQ_RESPOND:
        if (rd_req && rd_ack)
          state_nxt = SEQ_RELEASE;
      SEQ_RELEASE:
        if (!rd_ack)
          state_nxt = SEQ_IDLE;
      default:
        state_nxt = SEQ_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state   <= SEQ_IDLE;
      gap_cnt <= '0;
      wr_q    <= 1'b0;
      cmd_ack <= 1'b0;
      rd_req  <= 1'b0;
    end
    else
    begin
      state   <= state_nxt;
      gap_cnt <= (state == SEQ_GAP) ? gap_cnt_t'(gap_cnt + 1'b1) : '0;
      if (accept)
        wr_q <= cmd[CMD_WR_BIT];
      if (accept) // Ack follows the host, not the transfer
        cmd_ack <= 1'b1;
      else if (!cmd_req)
        cmd_ack <= 1'b0;
      if (state == SEQ_RESPOND && !rd_req)
        rd_req <= 1'b1;
      else if (rd_req && rd_ack)
        rd_req <= 1'b0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (accept)
      data_q <= cmd[7:0];
    if (state == SEQ_RESPOND && !rd_req)
    begin
      rd_data <= rx_byte;
      rd_err  <= rx_err;
    end
  end

  // Start bit goes out on the accepting edge
  assign tx_load    = accept || (state == SEQ_GAP && gap_done && wr_q);
  assign tx_byte    = (state == SEQ_IDLE) ? cmd[15:8] : data_q;
  assign timer_run  = (state == SEQ_SEND_HDR) || (state == SEQ_SEND_DATA) ||
                      (state == SEQ_RECV);
  assign timer_half = (state == SEQ_RECV);
  assign rx_arm     = (state == SEQ_WAIT_REPLY) || (state == SEQ_RECV);

endmodule

// ==== hdl/uart_cmd_top.sv ====
module uart_cmd_top (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       cmd_req,
  input  uart_frame_pkg::uart_cmd_t  cmd,
  output logic                       cmd_ack,
  output logic                       rd_req,
  input  logic                       rd_ack,
  output uart_frame_pkg::uart_byte_t rd_data,
  output logic                       rd_err,
  output logic                       tx,
  input  logic                       rx
);
  import uart_frame_pkg::*;

  logic          timer_run;
  logic          timer_half;
  logic          bit_tick;
  uart_bit_idx_t bit_idx;
  logic          frame_done;
  logic          tx_load;
  uart_byte_t    tx_byte;
  logic          rx_arm;
  logic          start_seen;
  uart_byte_t    rx_byte;
  logic          rx_err;

  uart_cmd_seq u_seq (
    .clk        (clk),
    .rst_n      (rst_n),
    .cmd_req    (cmd_req),
    .cmd        (cmd),
    .cmd_ack    (cmd_ack),
    .rd_req     (rd_req),
    .rd_ack     (rd_ack),
    .rd_data    (rd_data),
    .rd_err     (rd_err),
    .timer_run  (timer_run),
    .timer_half (timer_half),
    .frame_done (frame_done),
    .tx_load    (tx_load),
    .tx_byte    (tx_byte),
    .rx_arm     (rx_arm),
    .start_seen (start_seen),
    .rx_byte    (rx_byte),
    .rx_err     (rx_err)
  );

  // Shared time base, the link is half-duplex
  uart_baud_timer u_timer (
    .clk        (clk),
    .rst_n      (rst_n),
    .run        (timer_run),
    .half       (timer_half),
    .bit_tick   (bit_tick),
    .bit_idx    (bit_idx),
    .frame_done (frame_done)
  );

  uart_tx_shift u_tx (
    .clk      (clk),
    .rst_n    (rst_n),
    .load     (tx_load),
    .data     (tx_byte),
    .bit_tick (bit_tick),
    .tx       (tx)
  );

  uart_rx_shift u_rx (
    .clk        (clk),
    .rst_n      (rst_n),
    .rx         (rx),
    .arm        (rx_arm),
    .bit_tick   (bit_tick),
    .bit_idx    (bit_idx),
    .start_seen (start_seen),
    .data       (rx_byte),
    .err        (rx_err)
  );

endmodule

// ==== hdl/uart_ctrl_pkg.sv ====
package uart_ctrl_pkg;

  // Command sequencer states
  typedef enum logic [2:0] {
    SEQ_IDLE,
    SEQ_SEND_HDR,   // Upper command byte on tx
    SEQ_GAP,        // Fixed idle gap after header
    SEQ_SEND_DATA,  // Write data byte on tx
    SEQ_WAIT_REPLY, // Receiver armed, waiting for start bit
    SEQ_RECV,       // Reply frame coming in
    SEQ_RESPOND,    // rd_req up, waiting for rd_ack
    SEQ_RELEASE     // Waiting for rd_ack to drop
  } seq_state_t;

  // Holds up to UART_GAP_CYCLES - 1
  typedef logic [6:0] gap_cnt_t;

endpackage

// ==== hdl/uart_frame_pkg.sv ====
`include "uart_settings.svh"

package uart_frame_pkg;

  typedef logic [7:0]  uart_byte_t;    // Frame payload
  typedef logic [15:0] uart_cmd_t;     // {wr, addr[6:0], data[7:0]}
  typedef logic [3:0]  uart_bit_idx_t; // Bit position within a frame

  // --------------------------------------------------
  // Bit positions on the wire
  // --------------------------------------------------
  localparam uart_bit_idx_t BIT_IDX_START  = uart_bit_idx_t'(0);
  localparam uart_bit_idx_t BIT_IDX_STOP   = uart_bit_idx_t'(`UART_FRAME_BITS - 1);
  localparam uart_bit_idx_t BIT_IDX_PARITY = uart_bit_idx_t'(`UART_FRAME_BITS - 2);

  localparam int CMD_WR_BIT = 15;

endpackage

// ==== hdl/uart_rx_shift.sv ====
module uart_rx_shift (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          rx,
  input  logic                          arm,
  input  logic                          bit_tick,
  input  uart_frame_pkg::uart_bit_idx_t bit_idx,
  output logic                          start_seen,
  output uart_frame_pkg::uart_byte_t    data,
  output logic                          err
);
  import uart_frame_pkg::*;

  logic [2:0] sync_ff; // [1] is the synchronized line, [2] its last value
  logic       rx_s;
  logic       busy;    // Frame in progress
  logic       par_bit;
  logic       stop_tick;

  assign rx_s      = sync_ff[1];
  assign stop_tick = busy && bit_tick && (bit_idx == BIT_IDX_STOP);

  // First falling edge after arming
  assign start_seen = arm && !busy && sync_ff[2] && !sync_ff[1];

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      sync_ff <= '1;
    else
      sync_ff <= {sync_ff[1:0], rx};
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      busy <= 1'b0;
    else if (!arm)
      busy <= 1'b0;
    else if (start_seen)
      busy <= 1'b1;
    else if (stop_tick)
      busy <= 1'b0;
  end

  // --------------------------------------------------
  // Sampling at bit centers
  // --------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (busy && bit_tick)
    begin
      if (bit_idx == BIT_IDX_PARITY)
        par_bit <= rx_s;
      else if (bit_idx != BIT_IDX_START && bit_idx != BIT_IDX_STOP)
        data <= {rx_s, data[7:1]}; // LSB first
    end
  end

  // Bad parity or low stop bit
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      err <= 1'b0;
    else if (stop_tick)
      err <= ~(^{data, par_bit}) | ~rx_s;
  end

endmodule

// ==== hdl/uart_tx_shift.sv ====
`include "uart_settings.svh"

module uart_tx_shift (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       load,
  input  uart_frame_pkg::uart_byte_t data,
  input  logic                       bit_tick,
  output logic                       tx
);
  import uart_frame_pkg::*;

  logic [`UART_FRAME_BITS-1:0] frame_q; // Bit 0 is on the line
  logic                        parity;

  // Odd parity over data plus parity bit
  assign parity = ~^data;

  // --------------------------------------------------
  // Frame register
  // --------------------------------------------------
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      frame_q <= '1; // Line idles high
    else if (load)
      frame_q <= {1'b1, parity, data, 1'b0};
    else if (bit_tick)
      frame_q <= {1'b1, frame_q[`UART_FRAME_BITS-1:1]}; // Fill with ones
  end

  assign tx = frame_q[0];

endmodule

// ==== include/uart_settings.svh ====
`ifndef UART_SETTINGS_SVH
`define UART_SETTINGS_SVH

// Clock cycles per bit time, 4 or more
`define UART_BAUD_DIV 16

// Start edge to first sample point
`define UART_HALF_DIV (`UART_BAUD_DIV / 2)

// Start, 8 data, parity, stop
`define UART_FRAME_BITS 11

`define UART_GAP_CYCLES 100 // Idle cycles between frames

`endif

// ==== sim/tb_uart_cmd.sv ====
`include "uart_settings.svh"

module tb_uart_cmd;
  timeunit 1ns;
  timeprecision 1ps;

  import uart_frame_pkg::*;

  localparam int BIT_CYCLES   = `UART_BAUD_DIV;
  localparam int FRAME_CYCLES = `UART_FRAME_BITS * `UART_BAUD_DIV;
  localparam int WAIT_LIMIT   = 4000;
  localparam int MAX_TESTS    = 32;

  logic       clk;
  logic       rst_n;
  logic       cmd_req;
  uart_cmd_t  cmd;
  logic       cmd_ack;
  logic       rd_req;
  logic       rd_ack;
  uart_byte_t rd_data;
  logic       rd_err;
  logic       tx;
  logic       rx;

  logic [15:0] stim [0:3*MAX_TESTS-1]; // cmd, reply, flag per test
  int          errors;
  int          checks;
  int          n_tests;
  int          cyc;
  logic        timed_out;
  integer      seed;

  uart_cmd_top dut0 (
    .clk     (clk),
    .rst_n   (rst_n),
    .cmd_req (cmd_req),
    .cmd     (cmd),
    .cmd_ack (cmd_ack),
    .rd_req  (rd_req),
    .rd_ack  (rd_ack),
    .rd_data (rd_data),
    .rd_err  (rd_err),
    .tx      (tx),
    .rx      (rx)
  );

  bind uart_cmd_top uart_cmd_props u_props (
    .clk     (clk),
    .rst_n   (rst_n),
    .cmd_req (cmd_req),
    .cmd_ack (cmd_ack),
    .rd_req  (rd_req),
    .rd_ack  (rd_ack),
    .rd_data (rd_data),
    .rd_err  (rd_err),
    .tx      (tx)
  );

  always #50 clk = ~clk;

  always @(posedge clk)
    cyc <= cyc + 1;

  // Host drops its request once acknowledged
  always @(posedge clk)
    if (cmd_req && cmd_ack)
      cmd_req <= 1'b0;

  // --------------------------------------------------
  // Compare tasks
  // --------------------------------------------------
  task automatic check_byte(input string name, input uart_byte_t got, input uart_byte_t exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("Fail t=%0t %s got=%h exp=%h", $time, name, got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("Fail t=%0t %s got=%b exp=%b", $time, name, got, exp);
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    checks++;
    if (got != exp)
    begin
      errors++;
      $display("Fail t=%0t %s got=%0d exp=%0d", $time, name, got, exp);
    end
  endtask

  // --------------------------------------------------
  // Remote device side
  // --------------------------------------------------
  task automatic take_frame(input logic hdr, output uart_byte_t data, output int start_cyc);
    int   n;
    int   i;
    logic par;
    logic stop;
    n         = 0;
    data      = '0;
    start_cyc = 0;
    @(negedge clk);
    while (tx !== 1'b0 && n < WAIT_LIMIT)
    begin
      @(negedge clk);
      n++;
    end
    if (tx !== 1'b0)
    begin
      timed_out = 1'b1;
      $display("Timeout at %0t: no start bit appeared on tx", $time);
      return;
    end
    start_cyc = cyc;
    if (hdr)
      check_flag("cmd_ack", cmd_ack, 1'b1); // Same edge as the start bit
    repeat (`UART_HALF_DIV - 1) @(negedge clk);
    check_flag("tx_start", tx, 1'b0);
    for (i = 0; i < 8; i++)
    begin
      repeat (BIT_CYCLES) @(negedge clk);
      data[i] = tx; // LSB first
    end
    repeat (BIT_CYCLES) @(negedge clk);
    par = tx;
    repeat (BIT_CYCLES) @(negedge clk);
    stop = tx;
    check_flag("tx_parity", ^{data, par}, 1'b1);
    check_flag("tx_stop", stop, 1'b1);
  endtask

  task automatic idle_window(input int cycles, output logic quiet);
    quiet = 1'b1;
    repeat (cycles)
    begin
      @(negedge clk);
      if (tx !== 1'b1 || rd_req !== 1'b0)
        quiet = 1'b0;
    end
  endtask

  task automatic drive_reply(input uart_byte_t b, input logic bad_par);
    logic [`UART_FRAME_BITS-1:0] frame;
    int                          i;
    frame = {1'b1, (~^b) ^ bad_par, b, 1'b0};
    @(posedge clk);
    for (i = 0; i < `UART_FRAME_BITS; i++)
    begin
      rx <= frame[i];
      repeat (BIT_CYCLES) @(posedge clk);
    end
  endtask

  // Also watches that tx idles and cmd_ack stays low meanwhile
  task automatic wait_rd_req(input logic level, output logic quiet);
    int n;
    n     = 0;
    quiet = 1'b1;
    @(negedge clk);
    while (rd_req !== level && n < WAIT_LIMIT)
    begin
      if (tx !== 1'b1 || cmd_ack !== 1'b0)
        quiet = 1'b0;
      @(negedge clk);
      n++;
    end
    if (rd_req !== level)
    begin
      timed_out = 1'b1;
      $display("Timeout at %0t: rd_req never went to %0b", $time, level);
    end
  endtask

  // --------------------------------------------------
  // One line of the data file
  // --------------------------------------------------
  task automatic run_test(input int t);
    uart_cmd_t  c;
    uart_byte_t reply;
    uart_byte_t got;
    uart_byte_t held;
    logic       bad;
    logic       held_err;
    logic       ok;
    logic       kept;
    logic       idle;
    logic       no_ack;
    int         hdr_cyc;
    int         dat_cyc;
    int         delay;
    int         e0;
    c     = stim[3*t];
    reply = stim[3*t+1][7:0];
    bad   = stim[3*t+2][0];
    e0    = errors;
    if (!cmd_req) // Not already raised during the last read
    begin
      @(posedge clk);
      cmd     <= c;
      cmd_req <= 1'b1;
    end
    take_frame(1'b1, got, hdr_cyc);
    if (timed_out)
      return;
    check_byte("tx_header", got, c[15:8]);
    if (c[15])
    begin
      take_frame(1'b0, got, dat_cyc);
      if (timed_out)
        return;
      check_byte("tx_data", got, c[7:0]);
      check_count("frame_gap", dat_cyc - hdr_cyc, FRAME_CYCLES + `UART_GAP_CYCLES);
      idle_window(FRAME_CYCLES + `UART_GAP_CYCLES, ok);
      check_flag("write_tail_idle", ok, 1'b1);
    end
    else
    begin
      idle_window(BIT_CYCLES + `UART_GAP_CYCLES, ok); // Rest of stop bit and the gap
      check_flag("read_gap_idle", ok, 1'b1);
      // Reply goes out while the wait for rd_req runs
      fork
        drive_reply(reply, bad);
        wait_rd_req(1'b1, ok);
      join
      if (timed_out)
        return;
      @(negedge clk);
      check_flag("reply_wait_idle", ok, 1'b1);
      check_byte("rd_data", rd_data, reply);
      check_flag("rd_err", rd_err, bad);

      // Hold off rd_ack with the next command already requested
      delay    = ($random(seed) & 32'h1f) + 1;
      held     = rd_data;
      held_err = rd_err;
      kept     = 1'b1;
      idle     = 1'b1;
      no_ack   = 1'b1;
      @(posedge clk);
      if (t + 1 < n_tests)
      begin
        cmd     <= stim[3*(t+1)];
        cmd_req <= 1'b1;
      end
      repeat (delay)
      begin
        @(negedge clk);
        if (rd_data !== held || rd_err !== held_err)
          kept = 1'b0;
        if (tx !== 1'b1)
          idle = 1'b0;
        if (cmd_ack !== 1'b0)
          no_ack = 1'b0;
      end
      @(posedge clk);
      rd_ack <= 1'b1;
      wait_rd_req(1'b0, ok);
      if (timed_out)
        return;
      @(posedge clk);
      rd_ack <= 1'b0;
      @(negedge clk);
      if (cmd_ack !== 1'b0 || !ok)
        no_ack = 1'b0;
      check_flag("rd_data_held", kept, 1'b1);
      check_flag("tx_idle_in_respond", idle, 1'b1);
      check_flag("cmd_ack_held_off", no_ack, 1'b1);
    end
    $display("test %0d %s cmd=%h : %s", t + 1, c[15] ? "write" : "read ", c,
             (errors == e0) ? "ok" : "mismatch");
  endtask

  initial
  begin
    int t;
    int e0;
    clk       = 1'b0;
    rst_n     = 1'b0;
    cmd_req   = 1'b0;
    cmd       = '0;
    rd_ack    = 1'b0;
    rx        = 1'b1; // Line idles high
    errors    = 0;
    checks    = 0;
    n_tests   = 0;
    timed_out = 1'b0;
    seed      = 32'h7a92;
    $readmemh("sim/uart_cmd_input.txt", stim);
    while (n_tests < MAX_TESTS && !$isunknown(stim[3*n_tests]))
      n_tests++;

    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    e0 = errors;
    check_flag("tx", tx, 1'b1);
    check_flag("cmd_ack", cmd_ack, 1'b0);
    check_flag("rd_req", rd_req, 1'b0);
    $display("test 0 reset state : %s", (errors == e0) ? "ok" : "mismatch");

    t = 0;
    while (t < n_tests && !timed_out)
    begin
      run_test(t);
      t++;
    end

    $display("%0d tests from file, %0d checks, %0d errors, %0d assertion failures",
             n_tests, checks, errors, dut0.u_props.assert_fails);
    if (errors == 0 && dut0.u_props.assert_fails == 0 && !timed_out && n_tests > 0)
      $display(">>> PASS");
    else
      $display(">>> FAIL");
    $finish;
  end

endmodule

// ==== sim/uart_cmd_input.txt ====
// Columns: command (hex, bit 15 = write), reply byte, reply parity corruption flag
// Reply byte and flag are ignored for writes
85a5 00 0
0a00 3c 0
0b00 5a 1
ff00 00 0
1200 ff 0
9c81 00 0
7f00 00 1
c3e7 00 0
2000 81 0
4500 a6 1

// ==== sim/uart_cmd_props.sv ====
module uart_cmd_props (
  input logic                       clk,
  input logic                       rst_n,
  input logic                       cmd_req,
  input logic                       cmd_ack,
  input logic                       rd_req,
  input logic                       rd_ack,
  input uart_frame_pkg::uart_byte_t rd_data,
  input logic                       rd_err,
  input logic                       tx
);
  timeunit 1ns;
  timeprecision 1ps;

  logic acked_once;       // Some command has been acknowledged
  int   assert_fails = 0; // Failed assertions so far

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      acked_once <= 1'b0;
    else if (cmd_ack)
      acked_once <= 1'b1;
  end

  ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(cmd_ack) |-> $past(cmd_req))
    else
    begin
      $error("cmd_ack rose while cmd_req was low");
      assert_fails++;
    end

  // Read result frozen until the host answers
  rd_stable: assert property (@(posedge clk) disable iff (!rst_n)
    (rd_req && !rd_ack) |=> ($stable(rd_data) && $stable(rd_err)))
    else
    begin
      $error("rd_data or rd_err changed before rd_ack");
      assert_fails++;
    end

  rd_req_drop: assert property (@(posedge clk) disable iff (!rst_n)
    $fell(rd_req) |-> $past(rd_ack))
    else
    begin
      $error("rd_req fell without rd_ack");
      assert_fails++;
    end

  tx_idle_at_start: assert property (@(posedge clk) disable iff (!rst_n)
    !(acked_once || cmd_ack) |-> tx)
    else
    begin
      $error("tx left idle before the first command");
      assert_fails++;
    end

endmodule

// ==== sources.f ====
+incdir+include
hdl/uart_frame_pkg.sv
hdl/uart_ctrl_pkg.sv
hdl/uart_baud_timer.sv
hdl/uart_tx_shift.sv
hdl/uart_rx_shift.sv
hdl/uart_cmd_seq.sv
hdl/uart_cmd_top.sv
sim/uart_cmd_props.sv
sim/tb_uart_cmd.sv
